//--- src/nes_loader_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Cartridge loader types and constants
// iNES header layout, mapper flags word and the memory write beat
////////////////////////////////////////////////////////////////////////////

package nes_loader_pkg;

	localparam int ADDR_W        = 22;  // Cartridge memory address width
	localparam int HEADER_BYTES  = 16;
	localparam int PRG_UNIT_LOG2 = 14;  // 16 KiB per PRG page
	localparam int CHR_UNIT_LOG2 = 13;  // 8 KiB per CHR page

	// "NES" then 1A hex, first byte on top
	localparam logic [31:0] INES_MAGIC = 32'h4E45_531A;

	////////////////////////////////////////////////////////////////////////////
	// iNES header
	////////////////////////////////////////////////////////////////////////////

	// Named view, first stream byte in the top bits
	typedef struct packed {
		logic [3:0][7:0] magic;
		logic [7:0]      prg_pages;   // 16 KiB units
		logic [7:0]      chr_pages;   // 8 KiB units, zero means CHR RAM
		logic [7:0]      flags6;
		logic [7:0]      flags7;
		logic [7:0]      flags8;
		logic [7:0]      flags9;
		logic [5:0][7:0] tail;        // Bytes 10 to 15
	} ines_fields_t;

	// Same 128 bits seen as stream bytes, index 0 on top
	typedef union packed {
		logic [0:HEADER_BYTES-1][7:0] bytes;
		ines_fields_t                 fields;
	} ines_header_u;

	////////////////////////////////////////////////////////////////////////////
	// Mapper flags word handed to the console core
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0] reserved;
		logic       has_saves;    // Battery backed RAM present
		logic [7:0] submapper;    // NES 2.0 only
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;    // 1 = vertical
		logic [2:0] chr_size;     // log2 of CHR size in 8 KiB units
		logic [2:0] prg_size;     // log2 of PRG size in 16 KiB units
		logic [7:0] mapper;
	} mapper_flags_t;

	////////////////////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////////////////////

	// One byte write into cartridge memory
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_write_t;

endpackage

//--- src/ines_header_capture.sv
////////////////////////////////////////////////////////////////////////////
// iNES header capture
// Collects the first 16 stream bytes and checks magic and trainer flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ines_header_capture (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        load_start,
	input  logic [7:0]                  in_data,
	input  logic                        byte_take,     // Header byte accepted
	output nes_loader_pkg::ines_header_u header,
	output logic                        header_valid,  // One cycle after byte 16
	output logic                        header_ok
);

	import nes_loader_pkg::*;

	logic [3:0] byte_cnt;
	logic       full;       // All header bytes in, ignore further strobes
	logic       magic_ok;
	logic       capture;

	assign capture = byte_take && !full;

	// Byte counter and completion pulse
	always_ff @(posedge clk) begin
		if (reset_nes || load_start) begin
			byte_cnt     <= '0;
			full         <= 1'b0;
			header_valid <= 1'b0;
		end else begin
			header_valid <= 1'b0;
			if (capture) begin
				byte_cnt <= byte_cnt + 1'b1;
				if (byte_cnt == 4'(HEADER_BYTES - 1)) begin
					full         <= 1'b1;
					header_valid <= 1'b1;
				end
			end
		end
	end

	// Header storage
	always_ff @(posedge clk) begin
		if (capture)
			header.bytes[byte_cnt] <= in_data;
	end

	// Magic compared byte by byte against the stream order
	always_comb begin
		magic_ok = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (header.bytes[i] != INES_MAGIC[31 - 8*i -: 8])
				magic_ok = 1'b0;
		end
	end

	// Trainers are not supported
	assign header_ok = magic_ok && !header.fields.flags6[2];

	// At most one header per load
	a_single_header: assert property (
		@(posedge clk) disable iff (reset_nes)
		header_valid |=> (!header_valid) until load_start
	) else $error("header_valid repeated within one load");

endmodule

//--- src/mapper_flags_decode.sv
////////////////////////////////////////////////////////////////////////////
// Mapper flags decode
// Builds the 32-bit mapper flags word from a captured iNES header
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mapper_flags_decode (
	input  nes_loader_pkg::ines_header_u  header,
	input  logic                          invert_mirroring,
	output nes_loader_pkg::mapper_flags_t flags
);

	logic is_nes20;
	logic is_dirty;

	// Smallest k with pages <= 2**k, capped at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if ({1'b0, pages} <= (9'd1 << k))
				code = k[2:0];
		end
		return code;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Header format
	////////////////////////////////////////////////////////////////////////////

	assign is_nes20 = (header.fields.flags7[3:2] == 2'b10);

	// iNES 1.0 dumps with junk in the upper bytes
	assign is_dirty = !is_nes20 &&
	                  ((header.fields.flags9[7:1] != '0) || (header.fields.tail != '0));

	////////////////////////////////////////////////////////////////////////////
	// Flags word
	////////////////////////////////////////////////////////////////////////////

	assign flags.reserved    = '0;
	assign flags.has_saves   = header.fields.flags6[1];
	assign flags.submapper   = is_nes20 ? header.fields.flags8 : 8'h00;
	assign flags.four_screen = header.fields.flags6[3];
	assign flags.chr_ram     = (header.fields.chr_pages == 8'h00);
	assign flags.mirroring   = header.fields.flags6[0] ^ invert_mirroring;
	assign flags.chr_size    = size_code(header.fields.chr_pages);
	assign flags.prg_size    = size_code(header.fields.prg_pages);

	// High nibble untrusted on a dirty header
	assign flags.mapper = {is_dirty ? 4'h0 : header.fields.flags7[7:4],
	                       header.fields.flags6[7:4]};

endmodule

//--- src/rom_load_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// ROM load sequencer
// Steers header bytes to capture, then streams PRG and CHR to memory
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_load_sequencer #(
	parameter logic [nes_loader_pkg::ADDR_W-1:0] CHR_BASE = 22'h200000
) (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          load_start,
	input  logic [7:0]                    in_data,
	input  logic                          in_valid,
	input  logic                          mem_ready,
	input  nes_loader_pkg::ines_header_u  header,
	input  logic                          header_valid,
	input  logic                          header_ok,
	input  nes_loader_pkg::mapper_flags_t flags_in,
	output logic                          in_ready,
	output logic                          byte_take,
	output nes_loader_pkg::mem_write_t    mem_wr,
	output logic                          mem_valid,
	output logic                          busy,
	output logic                          done,
	output logic                          error,
	output nes_loader_pkg::mapper_flags_t flags
);

	import nes_loader_pkg::*;

	typedef enum logic [2:0] {
		ST_HEADER,
		ST_PRG,
		ST_CHR,
		ST_FINISHED,
		ST_FAILED
	} seq_state_t;

	seq_state_t        state;
	logic [ADDR_W-1:0] remaining;     // Bytes left in the current phase
	logic [ADDR_W-1:0] addr;
	logic [ADDR_W-1:0] prg_bytes;
	logic [ADDR_W-1:0] chr_bytes;
	logic              payload_phase;
	logic              pay_take;
	logic              phase_end;

	assign prg_bytes = {{(ADDR_W-8){1'b0}}, header.fields.prg_pages} << PRG_UNIT_LOG2;
	assign chr_bytes = {{(ADDR_W-8){1'b0}}, header.fields.chr_pages} << CHR_UNIT_LOG2;

	assign payload_phase = ((state == ST_PRG) || (state == ST_CHR)) && (remaining != '0);

	////////////////////////////////////////////////////////////////////////////
	// Stream steering
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			ST_HEADER:      in_ready = !header_valid;  // Hold off while header settles
			ST_PRG, ST_CHR: in_ready = mem_ready && (remaining != '0);
			default:        in_ready = 1'b1;           // Drain and discard
		endcase
	end

	assign byte_take = in_valid && in_ready && (state == ST_HEADER);

	// Payload goes straight through to the memory port
	assign mem_valid   = in_valid && payload_phase;
	assign mem_wr.addr = addr;
	assign mem_wr.data = in_data;

	assign pay_take  = mem_valid && mem_ready;
	assign phase_end = (remaining == '0) || (pay_take && (remaining == ADDR_W'(1)));

	////////////////////////////////////////////////////////////////////////////
	// Phase FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes || load_start) begin
			state     <= ST_HEADER;
			busy      <= 1'b0;
			done      <= 1'b0;
			error     <= 1'b0;
			remaining <= '0;
			addr      <= '0;
		end else begin
			case (state)
				ST_HEADER: begin
					if (header_valid) begin
						addr      <= '0;
						remaining <= prg_bytes;
						if (header_ok) begin
							state <= ST_PRG;
							busy  <= 1'b1;
						end else begin
							state <= ST_FAILED;
							error <= 1'b1;
							done  <= 1'b1;
						end
					end
				end
				ST_PRG, ST_CHR: begin
					if (phase_end) begin
						if (state == ST_PRG) begin
							state     <= ST_CHR;
							remaining <= chr_bytes;
							addr      <= CHR_BASE;
						end else begin
							state     <= ST_FINISHED;
							remaining <= '0;
							busy      <= 1'b0;
							done      <= 1'b1;
						end
					end else if (pay_take) begin
						remaining <= remaining - 1'b1;
						addr      <= addr + 1'b1;
					end
				end
				default: ;  // Finished or failed, wait for restart
			endcase
		end
	end

	// Flags survive load_start, only reset clears them
	always_ff @(posedge clk) begin
		if (reset_nes)
			flags <= '0;
		else if (header_valid)
			flags <= flags_in;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Every beat lands inside the region of its own phase
	a_mem_in_payload: assert property (
		@(posedge clk) disable iff (reset_nes)
		mem_valid |-> busy &&
		              (((state == ST_PRG) && (addr < prg_bytes)) ||
		               ((state == ST_CHR) && ((addr - CHR_BASE) < chr_bytes)))
	) else $error("memory write outside its PRG or CHR region");

	// Inside one phase the count only moves down
	a_count_no_wrap: assert property (
		@(posedge clk) disable iff (reset_nes || load_start)
		(state == $past(state)) |-> (remaining <= $past(remaining))
	) else $error("remaining byte count wrapped");

	a_busy_done: assert property (
		@(posedge clk) disable iff (reset_nes)
		!(busy && done)
	) else $error("busy and done high together");

endmodule

//--- src/nes_cart_loader.sv
////////////////////////////////////////////////////////////////////////////
// iNES cartridge loader top level
// Header capture, mapper decode and PRG/CHR write sequencing
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module nes_cart_loader #(
	parameter logic [nes_loader_pkg::ADDR_W-1:0] CHR_BASE = 22'h200000
) (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          load_start,
	input  logic [7:0]                    in_data,
	input  logic                          in_valid,
	input  logic                          mem_ready,
	input  logic                          invert_mirroring,
	output logic                          in_ready,
	output nes_loader_pkg::mem_write_t    mem_wr,
	output logic                          mem_valid,
	output logic                          busy,
	output logic                          done,
	output logic                          error,
	output nes_loader_pkg::mapper_flags_t flags
);

	import nes_loader_pkg::*;

	ines_header_u  header;
	logic          header_valid;
	logic          header_ok;
	logic          byte_take;
	mapper_flags_t flags_dec;    // Live decode, latched by the sequencer

	ines_header_capture i_ines_header_capture (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.load_start   (load_start),
		.in_data      (in_data),
		.byte_take    (byte_take),
		.header       (header),
		.header_valid (header_valid),
		.header_ok    (header_ok)
	);

	mapper_flags_decode i_mapper_flags_decode (
		.header           (header),
		.invert_mirroring (invert_mirroring),
		.flags            (flags_dec)
	);

	rom_load_sequencer #(
		.CHR_BASE (CHR_BASE)
	) i_rom_load_sequencer (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.load_start   (load_start),
		.in_data      (in_data),
		.in_valid     (in_valid),
		.mem_ready    (mem_ready),
		.header       (header),
		.header_valid (header_valid),
		.header_ok    (header_ok),
		.flags_in     (flags_dec),
		.in_ready     (in_ready),
		.byte_take    (byte_take),
		.mem_wr       (mem_wr),
		.mem_valid    (mem_valid),
		.busy         (busy),
		.done         (done),
		.error        (error),
		.flags        (flags)
	);

endmodule

//--- dv/nes_cart_loader_vectors.svh
////////////////////////////////////////////////////////////////////////////
// iNES header cases for the cartridge loader testbench
// Header fields with the mapper flags and error result each must give
////////////////////////////////////////////////////////////////////////////

`ifndef NES_CART_LOADER_VECTORS_SVH
`define NES_CART_LOADER_VECTORS_SVH

typedef struct packed {
	logic [7:0]   prg_pages;
	logic [7:0]   chr_pages;
	logic [7:0]   flags6;
	logic [7:0]   flags7;
	logic [7:0]   flags8;
	logic [7:0]   flags9;
	logic [47:0]  tail;        // Header bytes 10 to 15, byte 10 on top
	logic         magic_bad;   // Last magic byte sent as 1B hex
	logic         invert;      // invert_mirroring level
	logic [31:0]  exp_flags;
	logic         exp_error;
	logic [127:0] name;
} header_case_t;

localparam int NUM_CASES = 8;

header_case_t cases [NUM_CASES];

function automatic header_case_t make_case(
	input logic [7:0] prg, input logic [7:0] chr,
	input logic [7:0] f6, input logic [7:0] f7, input logic [7:0] f8, input logic [7:0] f9,
	input logic [47:0] tail, input logic magic_bad, input logic invert,
	input logic [31:0] exp_flags, input logic exp_error, input logic [127:0] name);
	return {prg, chr, f6, f7, f8, f9, tail, magic_bad, invert, exp_flags, exp_error, name};
endfunction

// Flags as {reserved, has_saves, submapper, four_screen, chr_ram,
//           mirroring, chr_size, prg_size, mapper}
task automatic load_cases();
	cases[0] = make_case(8'd1, 8'd1, 8'h01, 8'h00, 8'h00, 8'h00, 48'h0, 1'b0, 1'b0,
		{6'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 3'd0, 3'd0, 8'h00}, 1'b0, "basic_nrom");
	cases[1] = make_case(8'd2, 8'd0, 8'h12, 8'h00, 8'h00, 8'h00, 48'h0, 1'b0, 1'b1,
		{6'b0, 1'b1, 8'h00, 1'b0, 1'b1, 1'b1, 3'd0, 3'd1, 8'h01}, 1'b0, "chr_ram_inv");
	cases[2] = make_case(8'd3, 8'd2, 8'h48, 8'h18, 8'h25, 8'hF0, 48'h7, 1'b0, 1'b0,
		{6'b0, 1'b0, 8'h25, 1'b1, 1'b0, 1'b0, 3'd1, 3'd2, 8'h14}, 1'b0, "nes20_sub");
	cases[3] = make_case(8'd1, 8'd1, 8'h21, 8'h40, 8'h33, 8'h00, 48'h4469_736B_4475,
		1'b0, 1'b1, {6'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'h02}, 1'b0,
		"dirty_tail");
	cases[4] = make_case(8'd1, 8'd1, 8'h30, 8'h70, 8'h00, 8'h02, 48'h0, 1'b0, 1'b0,
		{6'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'h03}, 1'b0, "dirty_flags9");
	cases[5] = make_case(8'd1, 8'd1, 8'h30, 8'h70, 8'h00, 8'h01, 48'h0, 1'b0, 1'b0,
		{6'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'h73}, 1'b0, "clean_flags9");
	// Large page counts only where no payload follows
	cases[6] = make_case(8'h40, 8'h41, 8'h01, 8'h00, 8'h00, 8'h00, 48'h0, 1'b1, 1'b0,
		{6'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 3'd7, 3'd6, 8'h00}, 1'b1, "bad_magic");
	cases[7] = make_case(8'hC8, 8'h05, 8'hA4, 8'h00, 8'h00, 8'h00, 48'h0, 1'b0, 1'b0,
		{6'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd3, 3'd7, 8'h0A}, 1'b1, "trainer");
endtask

`endif

//--- dv/nes_cart_loader_tb.sv
////////////////////////////////////////////////////////////////////////////
// Cartridge loader testbench
// Streams iNES images through the loader and checks every memory write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module nes_cart_loader_tb;

	import nes_loader_pkg::*;

	localparam int                CLK_PERIOD   = 8;
	localparam logic [ADDR_W-1:0] CHR_BASE     = 22'h100000;
	localparam int                BYTE_TIMEOUT = 1000;  // Cycles per input byte
	localparam int                DONE_TIMEOUT = 16;
	localparam int                DRAIN_BYTES  = 32;

	logic          clk;
	logic          reset_nes;
	logic          load_start;
	logic [7:0]    in_data;
	logic          in_valid;
	logic          mem_ready;
	logic          invert_mirroring;
	logic          in_ready;
	mem_write_t    mem_wr;
	logic          mem_valid;
	logic          busy;
	logic          done;
	logic          error;
	mapper_flags_t flags;

	int    seed = 32'h1749;
	bit    stall_en;      // Random input gaps and memory stalls
	int    prg_len;
	int    chr_len;
	int    wr_count;
	string case_name;

	`include "nes_cart_loader_vectors.svh"

	nes_cart_loader #(
		.CHR_BASE (CHR_BASE)
	) i_nes_cart_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.load_start       (load_start),
		.in_data          (in_data),
		.in_valid         (in_valid),
		.mem_ready        (mem_ready),
		.invert_mirroring (invert_mirroring),
		.in_ready         (in_ready),
		.mem_wr           (mem_wr),
		.mem_valid        (mem_valid),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.flags            (flags)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] exp,
	                           input logic [31:0] act);
		if (exp !== act)
			abort_run($sformatf("[ERROR] %s %s: expected %h, actual %h",
			                    case_name, what, exp, act));
	endtask

	// PRG from zero, CHR from the base, in stream order
	function automatic logic [ADDR_W-1:0] payload_addr(input int n);
		if (n < prg_len)
			return ADDR_W'(n);
		else
			return CHR_BASE + ADDR_W'(n - prg_len);
	endfunction

	function automatic logic [7:0] payload_byte(input logic [ADDR_W-1:0] addr);
		return 8'(addr % 251);
	endfunction

	task automatic send_byte(input logic [7:0] value);
		int waited;
		bit sent;
		bit offered;    // Valid stays up once raised
		waited  = 0;
		sent    = 1'b0;
		offered = 1'b0;
		while (!sent) begin
			@(negedge clk);
			mem_ready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
			in_valid  = (stall_en && !offered) ? (($random(seed) & 3) != 0) : 1'b1;
			in_data   = value;
			offered   = in_valid;
			#1;
			sent = in_valid && in_ready;    // Transfer on the coming rising edge
			waited++;
			if (!sent && waited > BYTE_TIMEOUT)
				abort_run($sformatf("Timeout in %s: input byte never accepted", case_name));
		end
	endtask

	task automatic wait_for_done(input int limit, output int waited);
		waited = 0;
		@(negedge clk);
		in_valid = 1'b0;
		#1;
		while (!done) begin
			if (waited >= limit)
				abort_run($sformatf("Timeout in %s: done never rose", case_name));
			waited++;
			@(negedge clk);
			in_valid = 1'b0;
			#1;
		end
	endtask

	// Trailing bytes must be taken every cycle and dropped
	task automatic send_discard(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			mem_ready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
			in_valid  = 1'b1;
			in_data   = 8'(8'hA5 ^ i);
			#1;
			check_value("in_ready after done", 1, in_ready);
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory side monitor
	////////////////////////////////////////////////////////////////////////////

	always begin
		@(negedge clk);
		#3;
		if (mem_valid && mem_ready) begin
			if (wr_count >= prg_len + chr_len)
				abort_run($sformatf("Unexpected memory write to %h in %s",
				                    mem_wr.addr, case_name));
			check_value("busy during write", 1, busy);
			check_value("write address", payload_addr(wr_count), mem_wr.addr);
			check_value("write data", payload_byte(payload_addr(wr_count)), mem_wr.data);
			wr_count++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// One header case
	////////////////////////////////////////////////////////////////////////////

	task automatic run_case(input header_case_t cur);
		logic [7:0]  hdr [HEADER_BYTES];
		logic [31:0] prev_flags;
		int          total;
		int          waited;
		case_name  = $sformatf("%s", cur.name);
		prg_len    = cur.exp_error ? 0 : int'(cur.prg_pages) * 16384;
		chr_len    = cur.exp_error ? 0 : int'(cur.chr_pages) * 8192;
		total      = prg_len + chr_len;
		wr_count   = 0;
		hdr[0]     = 8'h4E;  // "NES" then 1A
		hdr[1]     = 8'h45;
		hdr[2]     = 8'h53;
		hdr[3]     = cur.magic_bad ? 8'h1B : 8'h1A;
		hdr[4]     = cur.prg_pages;
		hdr[5]     = cur.chr_pages;
		hdr[6]     = cur.flags6;
		hdr[7]     = cur.flags7;
		hdr[8]     = cur.flags8;
		hdr[9]     = cur.flags9;
		for (int i = 0; i < 6; i++)
			hdr[10 + i] = cur.tail[47 - 8*i -: 8];

		@(negedge clk);
		prev_flags       = flags;
		load_start       = 1'b1;
		invert_mirroring = cur.invert;
		in_valid         = 1'b0;
		mem_ready        = 1'b1;
		@(negedge clk);
		load_start = 1'b0;
		#1;
		check_value("busy after start", 0, busy);
		check_value("done after start", 0, done);
		check_value("error after start", 0, error);
		check_value("mem_valid after start", 0, mem_valid);
		check_value("in_ready after start", 1, in_ready);
		check_value("flags kept over load_start", prev_flags, flags);

		for (int i = 0; i < HEADER_BYTES; i++)
			send_byte(hdr[i]);
		for (int n = 0; n < total; n++)
			send_byte(payload_byte(payload_addr(n)));

		// One extra cycle when the CHR phase or the header check comes last
		wait_for_done(DONE_TIMEOUT, waited);
		check_value("cycles from last byte to done", (chr_len == 0) ? 1 : 0, waited);
		check_value("busy at end", 0, busy);
		check_value("error", cur.exp_error, error);
		check_value("flags", cur.exp_flags, flags);
		check_value("write count", total, wr_count);

		send_discard(DRAIN_BYTES);
		check_value("write count after drain", total, wr_count);
		check_value("done after drain", 1, done);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset_nes        = 1'b1;
		load_start       = 1'b0;
		in_data          = 8'h00;
		in_valid         = 1'b0;
		mem_ready        = 1'b1;
		invert_mirroring = 1'b0;
		stall_en         = 1'b0;
		prg_len          = 0;
		chr_len          = 0;
		wr_count         = 0;
		case_name        = "reset";
		load_cases();

		repeat (8) @(posedge clk);
		@(negedge clk);
		reset_nes = 1'b0;
		#1;
		check_value("flags after reset", 0, flags);
		check_value("in_ready after reset", 1, in_ready);

		run_case(cases[0]);  // Unstalled reference run
		stall_en = 1'b1;
		for (int i = 0; i < NUM_CASES; i++)
			run_case(cases[i]);

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- nes_cart_loader.f
+incdir+dv
src/nes_loader_pkg.sv
src/ines_header_capture.sv
src/mapper_flags_decode.sv
src/rom_load_sequencer.sv
src/nes_cart_loader.sv
dv/nes_cart_loader_tb.sv

//--- Bender.yml
package:
  name: nes_cart_loader

sources:
  - src/nes_loader_pkg.sv
  - src/ines_header_capture.sv
  - src/mapper_flags_decode.sv
  - src/rom_load_sequencer.sv
  - src/nes_cart_loader.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/nes_cart_loader_tb.sv
